// File: hw/pipe_pkg.sv
package pipe_pkg;

    // Datapath widths
    localparam int data_w     = 16;
    localparam int instr_w    = 16;
    localparam int reg_addr_w = 3;
    localparam int imm_w      = 6;

    // Instruction field positions
    localparam int op_msb  = 15;
    localparam int op_lsb  = 12;
    localparam int rd_msb  = 11;
    localparam int rd_lsb  = 9;
    localparam int rs1_msb = 8;
    localparam int rs1_lsb = 6;
    localparam int rs2_msb = 5;
    localparam int rs2_lsb = 3;
    localparam int imm_msb = 5;
    localparam int imm_lsb = 0;

    // NOP must stay at zero, an all-zero word is the pipeline bubble
    typedef enum logic [3:0] {
        NOP, ADD, SUB, AND_OP, OR_OP, XOR_OP, ADDI, LD, ST, HALT
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE, RUN, DRAIN, DONE
    } ctrl_state_t;

endpackage

// File: hw/instr_fetch.sv
module instr_fetch import pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    localparam int imem_aw = $clog2(IMEM_DEPTH)
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               imem_we,
    input  logic [imem_aw-1:0] imem_addr,
    input  logic [instr_w-1:0] imem_data,
    input  logic               fetch_en,
    input  logic               advance,
    input  logic               hold_id,
    output logic [instr_w-1:0] id_instr
);

    logic [instr_w-1:0] imem [IMEM_DEPTH];
    logic [imem_aw-1:0] pc;

    // Program load is locked out while the pipeline fetches
    always_ff @(posedge clk) begin
        if (imem_we && !fetch_en) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (start && !fetch_en) begin
            pc <= '0;
        end else if (advance && !hold_id && fetch_en) begin
            pc <= pc + 1'b1;
        end
    end

    // IF/ID fills with NOP once fetch stops, so nothing stale reaches decode
    always_ff @(posedge clk) begin
        if (rst) begin
            id_instr <= '0;
        end else if (advance && !hold_id) begin
            id_instr <= fetch_en ? imem[pc] : '0;
        end
    end

endmodule

// File: hw/decode_regfile.sv
module decode_regfile import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic                  hold_id,
    input  logic [instr_w-1:0]    id_instr,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_we,
    input  logic [data_w-1:0]     wb_data,
    output logic [reg_addr_w-1:0] id_rs1,
    output logic [reg_addr_w-1:0] id_rs2,
    output logic                  id_uses_rs2,
    output logic                  id_is_halt,
    output opcode_t               ex_op,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic                  ex_we,
    output logic [data_w-1:0]     ex_a,
    output logic [data_w-1:0]     ex_b,
    output logic [data_w-1:0]     ex_imm
);

    opcode_t               id_op;
    logic                  id_uses_rs1;
    logic                  id_writes;
    logic [reg_addr_w-1:0] id_rd;
    logic [data_w-1:0]     id_imm;
    logic [data_w-1:0]     rd_a;
    logic [data_w-1:0]     rd_b;
    logic [data_w-1:0]     regs [2**reg_addr_w];

    // Entry 0 is never written and reads back as zero
    function automatic logic [data_w-1:0] read_reg(input logic [reg_addr_w-1:0] a);
        if (a == '0) begin
            return '0;
        end
        // Write-through from WB removes the need to stall on that stage
        if (wb_we && wb_rd == a) begin
            return wb_data;
        end
        return regs[a];
    endfunction

    assign id_op  = opcode_t'(id_instr[op_msb:op_lsb]);
    assign id_rd  = id_instr[rd_msb:rd_lsb];
    assign id_imm = {{(data_w - imm_w){id_instr[imm_msb]}}, id_instr[imm_msb:imm_lsb]};

    always_comb begin
        id_uses_rs1 = 1'b0;
        id_uses_rs2 = 1'b0;
        id_writes   = 1'b0;
        case (id_op)
            ADD, SUB, AND_OP, OR_OP, XOR_OP: begin
                id_uses_rs1 = 1'b1;
                id_uses_rs2 = 1'b1;
                id_writes   = 1'b1;
            end
            ADDI, LD: begin
                id_uses_rs1 = 1'b1;
                id_writes   = 1'b1;
            end
            ST: begin
                id_uses_rs1 = 1'b1;
                id_uses_rs2 = 1'b1;
            end
            default: begin
                id_writes = 1'b0;
            end
        endcase
    end

    // Unused source fields report as r0 so they never match a hazard
    assign id_rs1     = id_uses_rs1 ? id_instr[rs1_msb:rs1_lsb] : '0;
    assign id_rs2     = id_uses_rs2 ? id_instr[rs2_msb:rs2_lsb] : '0;
    assign id_is_halt = (id_op == HALT);

    always_comb begin
        rd_a = read_reg(id_rs1);
        rd_b = read_reg(id_rs2);
    end

    always_ff @(posedge clk) begin
        if (advance && wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_op <= NOP;
            ex_we <= 1'b0;
        end else if (advance) begin
            // Bubble into EX while decode is stalled
            ex_op <= hold_id ? NOP : id_op;
            ex_we <= hold_id ? 1'b0 : id_writes;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_rd  <= id_rd;
            ex_a   <= rd_a;
            ex_b   <= rd_b;
            ex_imm <= id_imm;
        end
    end

endmodule

// File: hw/pipe_ctrl.sv
module pipe_ctrl import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  mem_wait,
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,
    input  logic                  id_uses_rs2,
    input  logic                  id_is_halt,
    input  logic                  ex_we,
    input  logic                  mem_we,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [reg_addr_w-1:0] mem_rd,
    output logic                  advance,
    output logic                  hold_id,
    output logic                  fetch_en,
    output logic                  v_id,
    output logic                  v_ex,
    output logic                  v_mem,
    output logic                  v_wb,
    output logic                  busy
);

    ctrl_state_t state;
    logic        ex_hit;
    logic        mem_hit;
    logic        halt_in_id;

    // RAW check against the two stages ahead of decode
    assign ex_hit = v_ex && ex_we && (ex_rd != '0) &&
                    ((ex_rd == id_rs1) || (id_uses_rs2 && ex_rd == id_rs2));
    assign mem_hit = v_mem && mem_we && (mem_rd != '0) &&
                     ((mem_rd == id_rs1) || (id_uses_rs2 && mem_rd == id_rs2));
    assign hold_id = v_id && (ex_hit || mem_hit);

    assign halt_in_id = v_id && id_is_halt;
    assign busy       = (state == RUN) || (state == DRAIN);
    assign advance    = busy && !mem_wait;
    // Fetch stops as soon as HALT shows up in decode
    assign fetch_en   = (state == RUN) && !halt_in_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (advance && halt_in_id) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (!v_ex && !v_mem && !v_wb) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_id  <= 1'b0;
            v_ex  <= 1'b0;
            v_mem <= 1'b0;
            v_wb  <= 1'b0;
        end else if (advance) begin
            v_wb  <= v_mem;
            v_mem <= v_ex;
            if (hold_id) begin
                v_ex <= 1'b0;
            end else begin
                // HALT leaves decode but never becomes a valid instruction
                v_ex <= v_id && !id_is_halt;
                v_id <= fetch_en;
            end
        end
    end

endmodule

// File: hw/exec_alu.sv
module exec_alu import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  opcode_t               ex_op,
    input  logic [data_w-1:0]     ex_a,
    input  logic [data_w-1:0]     ex_b,
    input  logic [data_w-1:0]     ex_imm,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic                  ex_we,
    output opcode_t               mem_op,
    output logic [reg_addr_w-1:0] mem_rd,
    output logic                  mem_we,
    output logic [data_w-1:0]     mem_result,
    output logic [data_w-1:0]     mem_store_data
);

    logic [data_w-1:0] alu_y;

    always_comb begin
        case (ex_op)
            ADD:         alu_y = ex_a + ex_b;
            SUB:         alu_y = ex_a - ex_b;
            AND_OP:      alu_y = ex_a & ex_b;
            OR_OP:       alu_y = ex_a | ex_b;
            XOR_OP:      alu_y = ex_a ^ ex_b;
            // Loads and stores share the ADDI adder for the address
            ADDI, LD, ST: alu_y = ex_a + ex_imm;
            default:     alu_y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_op <= NOP;
            mem_we <= 1'b0;
        end else if (advance) begin
            mem_op <= ex_op;
            mem_we <= ex_we;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            mem_rd         <= ex_rd;
            mem_result     <= alu_y;
            mem_store_data <= ex_b;
        end
    end

endmodule

// File: hw/mem_stage.sv
module mem_stage import pipe_pkg::*; #(
    parameter int DMEM_DEPTH = 32,
    localparam int dmem_aw = $clog2(DMEM_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  opcode_t               mem_op,
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic                  mem_we,
    input  logic [data_w-1:0]     mem_result,
    input  logic [data_w-1:0]     mem_store_data,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic                  wb_we,
    output logic [data_w-1:0]     wb_data
);

    logic [data_w-1:0]  dmem [DMEM_DEPTH];
    logic [dmem_aw-1:0] addr;

    // Upper address bits are ignored, the memory wraps
    assign addr = mem_result[dmem_aw-1:0];

    always_ff @(posedge clk) begin
        if (advance && mem_op == ST) begin
            dmem[addr] <= mem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else if (advance) begin
            wb_we <= mem_we;
        end
    end

    // Synchronous read lands directly in the MEM/WB register
    always_ff @(posedge clk) begin
        if (advance) begin
            wb_rd   <= mem_rd;
            wb_data <= (mem_op == LD) ? dmem[addr] : mem_result;
        end
    end

endmodule

// File: hw/retire_tracker.sv
module retire_tracker import pipe_pkg::*; #(
    parameter int SEQ_W = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  advance,
    input  logic                  hold_id,
    input  logic                  v_id,
    input  logic                  v_wb,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_we,
    input  logic [data_w-1:0]     wb_data,
    output logic                  retire,
    output logic [SEQ_W-1:0]      retire_seq,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic                  retire_we,
    output logic [data_w-1:0]     retire_data,
    output logic [3:0]            retire_stalls
);

    logic [3:0]       id_stalls;
    logic [3:0]       ex_stalls;
    logic [3:0]       mem_stalls;
    logic [3:0]       wb_stalls;
    logic [SEQ_W-1:0] issue_cnt;
    logic [SEQ_W-1:0] ex_seq;
    logic [SEQ_W-1:0] mem_seq;
    logic [SEQ_W-1:0] wb_seq;
    logic             issue;

    assign issue = advance && v_id && !hold_id;

    always_ff @(posedge clk) begin
        if (rst || start) begin
            id_stalls <= '0;
            issue_cnt <= '0;
        end else if (advance) begin
            if (!hold_id) begin
                id_stalls <= '0;
            end else if (id_stalls != 4'hf) begin
                id_stalls <= id_stalls + 4'd1;
            end
            if (issue) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
        end
    end

    // Record slots shadow ID/EX, EX/MEM and MEM/WB
    always_ff @(posedge clk) begin
        if (advance) begin
            ex_stalls  <= hold_id ? 4'd0 : id_stalls;
            ex_seq     <= issue_cnt;
            mem_stalls <= ex_stalls;
            mem_seq    <= ex_seq;
            wb_stalls  <= mem_stalls;
            wb_seq     <= mem_seq;
        end
    end

    assign retire        = v_wb && advance;
    assign retire_seq    = wb_seq;
    assign retire_stalls = wb_stalls;
    assign retire_rd     = wb_rd;
    assign retire_we     = wb_we;
    assign retire_data   = wb_data;

endmodule

// File: hw/pipe_top.sv
module pipe_top import pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 32,
    parameter int SEQ_W      = 8,
    localparam int imem_aw = $clog2(IMEM_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  imem_we,
    input  logic [imem_aw-1:0]    imem_addr,
    input  logic [instr_w-1:0]    imem_data,
    input  logic                  start,
    input  logic                  mem_wait,
    output logic                  busy,
    output logic                  retire,
    output logic [SEQ_W-1:0]      retire_seq,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic                  retire_we,
    output logic [data_w-1:0]     retire_data,
    output logic [3:0]            retire_stalls
);

    logic                  advance;
    logic                  hold_id;
    logic                  fetch_en;
    logic                  v_id;
    logic                  v_ex;
    logic                  v_mem;
    logic                  v_wb;
    logic [instr_w-1:0]    id_instr;
    logic [reg_addr_w-1:0] id_rs1;
    logic [reg_addr_w-1:0] id_rs2;
    logic                  id_uses_rs2;
    logic                  id_is_halt;
    opcode_t               ex_op;
    logic [reg_addr_w-1:0] ex_rd;
    logic                  ex_we;
    logic [data_w-1:0]     ex_a;
    logic [data_w-1:0]     ex_b;
    logic [data_w-1:0]     ex_imm;
    opcode_t               mem_op;
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_we;
    logic [data_w-1:0]     mem_result;
    logic [data_w-1:0]     mem_store_data;
    logic [reg_addr_w-1:0] wb_rd;
    logic                  wb_we;
    logic [data_w-1:0]     wb_data;

    pipe_ctrl pipe_ctrl_i (
        .clk, .rst, .start, .mem_wait,
        .id_rs1, .id_rs2, .id_uses_rs2, .id_is_halt,
        .ex_we, .mem_we, .ex_rd, .mem_rd,
        .advance, .hold_id, .fetch_en,
        .v_id, .v_ex, .v_mem, .v_wb, .busy
    );

    instr_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) instr_fetch_i (
        .clk, .rst, .start, .imem_we, .imem_addr, .imem_data,
        .fetch_en, .advance, .hold_id, .id_instr
    );

    decode_regfile decode_regfile_i (
        .clk, .rst, .advance, .hold_id, .id_instr,
        .wb_rd, .wb_we, .wb_data,
        .id_rs1, .id_rs2, .id_uses_rs2, .id_is_halt,
        .ex_op, .ex_rd, .ex_we, .ex_a, .ex_b, .ex_imm
    );

    exec_alu exec_alu_i (
        .clk, .rst, .advance, .ex_op, .ex_a, .ex_b, .ex_imm, .ex_rd, .ex_we,
        .mem_op, .mem_rd, .mem_we, .mem_result, .mem_store_data
    );

    mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) mem_stage_i (
        .clk, .rst, .advance, .mem_op, .mem_rd, .mem_we,
        .mem_result, .mem_store_data,
        .wb_rd, .wb_we, .wb_data
    );

    retire_tracker #(.SEQ_W(SEQ_W)) retire_tracker_i (
        .clk, .rst, .start, .advance, .hold_id, .v_id, .v_wb,
        .wb_rd, .wb_we, .wb_data,
        .retire, .retire_seq, .retire_rd, .retire_we, .retire_data, .retire_stalls
    );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // Free running, first rising edge half a period in
    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: verif/pipe_assertions.sv
module pipe_assertions #(
    parameter int SEQ_W = 8
) (
    input logic             clk,
    input logic             rst,
    input logic             mem_wait,
    input logic             busy,
    input logic             retire,
    input logic             hold_id,
    input logic [SEQ_W-1:0] retire_seq
);
    timeunit 1ns;
    timeprecision 100ps;

    logic             have_prev;
    logic [SEQ_W-1:0] prev_seq;

    // Last retired sequence number within the current run
    always_ff @(posedge clk) begin
        if (rst || !busy) begin
            have_prev <= 1'b0;
        end else if (retire) begin
            have_prev <= 1'b1;
            prev_seq  <= retire_seq;
        end
    end

    no_retire_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem_wait |-> !retire) else $error("retire during mem_wait");

    idle_after_reset: assert property (@(posedge clk)
        rst |=> !busy) else $error("busy right after reset");

    seq_steps_by_one: assert property (@(posedge clk) disable iff (rst)
        retire && have_prev |-> retire_seq == SEQ_W'(prev_seq + 1'b1))
        else $error("retire_seq skipped");

    stall_only_when_busy: assert property (@(posedge clk) disable iff (rst)
        hold_id |-> busy) else $error("hazard stall outside a run");

endmodule

bind pipe_top pipe_assertions #(.SEQ_W(SEQ_W)) pipe_assertions_i (
    .clk, .rst, .mem_wait, .busy, .retire, .hold_id, .retire_seq
);

// File: verif/pipe_tb.sv
module pipe_tb import pipe_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 32;
    localparam int SEQ_W      = 8;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int STIM_WORDS = 256;
    localparam int MAX_WIN    = 8;

    logic                  clk;
    logic                  rst;
    logic                  imem_we;
    logic [IMEM_AW-1:0]    imem_addr;
    logic [instr_w-1:0]    imem_data;
    logic                  start;
    logic                  mem_wait;
    logic                  busy;
    logic                  retire;
    logic [SEQ_W-1:0]      retire_seq;
    logic [reg_addr_w-1:0] retire_rd;
    logic                  retire_we;
    logic [data_w-1:0]     retire_data;
    logic [3:0]            retire_stalls;

    logic [31:0] stim [STIM_WORDS];
    int          win_start [MAX_WIN];
    int          win_len [MAX_WIN];
    int          n_win;
    int          pos;
    int          n_tests;
    int          test_num;
    int          rec_num;
    int          checks;
    int          errors;
    int          cycles;
    int          cycle_limit;

    tb_clk_gen #(.PERIOD_NS(20)) tb_clk_gen_i (.clk);

    pipe_top #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH),
        .SEQ_W(SEQ_W)
    ) pipe_top_i (
        .clk, .rst, .imem_we, .imem_addr, .imem_data, .start, .mem_wait,
        .busy, .retire, .retire_seq, .retire_rd, .retire_we, .retire_data, .retire_stalls
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL test %0d record %0d %s: got 0x%0h, expected 0x%0h",
                     test_num, rec_num, name, got, exp);
        end
    endtask

    // Record word holds rd, we, stalls and data from top to bottom
    task automatic compare_record(input logic [31:0] rec);
        check_value("retire_seq", 32'(retire_seq), 32'(rec_num));
        check_value("retire_we", 32'(retire_we), 32'(rec[27:24]));
        check_value("retire_stalls", 32'(retire_stalls), 32'(rec[23:16]));
        if (rec[24]) begin
            check_value("retire_rd", 32'(retire_rd), 32'(rec[31:28]));
            check_value("retire_data", 32'(retire_data), 32'(rec[15:0]));
        end
    endtask

    function automatic logic in_wait_window(input int k);
        int w;
        for (w = 0; w < n_win; w++) begin
            if (k >= win_start[w] && k < win_start[w] + win_len[w]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Load and run take about twice the program length, stalls add at most two per word
    function automatic int compute_cycle_limit();
        int p;
        int t;
        int w;
        int len;
        int total;
        p     = 1;
        len   = 0;
        total = 20;
        for (t = 0; t < n_tests; t++) begin
            if (stim[p] != 0) begin
                len = int'(stim[p]);
            end
            p = p + int'(stim[p]) + 1;
            for (w = 0; w < int'(stim[p]); w++) begin
                total = total + int'(stim[p + 2 + 2 * w]);
            end
            p = p + 2 * int'(stim[p]) + 1;
            p = p + int'(stim[p]) + 1;
            total = total + 4 * len + 10;
        end
        return total;
    endfunction

    task automatic run_test();
        int n_prog;
        int n_exp;
        int exp_pos;
        int i;
        int k;
        int retired;
        int errors_before;
        errors_before = errors;
        // A program count of zero keeps the program already in memory
        n_prog = int'(stim[pos]);
        for (i = 0; i < n_prog; i++) begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = IMEM_AW'(i);
            imem_data = stim[pos + 1 + i][instr_w-1:0];
        end
        pos   = pos + n_prog + 1;
        n_win = int'(stim[pos]);
        for (i = 0; i < n_win && i < MAX_WIN; i++) begin
            win_start[i] = int'(stim[pos + 1 + 2 * i]);
            win_len[i]   = int'(stim[pos + 2 + 2 * i]);
        end
        pos     = pos + 2 * n_win + 1;
        n_exp   = int'(stim[pos]);
        exp_pos = pos + 1;
        pos     = pos + n_exp + 1;

        @(negedge clk);
        imem_we = 1'b0;
        start   = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        retired  = 0;
        k        = 0;
        mem_wait = in_wait_window(k);
        // Outputs settle after the falling edge and hold until the next rising edge
        #1;
        while (busy) begin
            if (retire) begin
                rec_num = retired;
                if (retired < n_exp) begin
                    compare_record(stim[exp_pos + retired]);
                end
                retired++;
            end
            @(negedge clk);
            k++;
            mem_wait = in_wait_window(k);
            #1;
        end
        @(negedge clk);
        mem_wait = 1'b0;

        if (retired != n_exp) begin
            errors++;
            $display("Test %0d retired %0d instructions but %0d were expected",
                     test_num, retired, n_exp);
        end
        if (errors == errors_before) begin
            $display("test %0d ok, %0d retired", test_num, retired);
        end else begin
            $display("test %0d had %0d errors, %0d retired",
                     test_num, errors - errors_before, retired);
        end
    endtask

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        mem_wait  = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        checks    = 0;
        errors    = 0;
        $readmemh("verif/pipe_stimulus.txt", stim);
        n_tests     = int'(stim[0]);
        cycle_limit = compute_cycle_limit();
        repeat (16) @(negedge clk);
        rst = 1'b0;

        pos = 1;
        for (test_num = 1; test_num <= n_tests; test_num++) begin
            run_test();
        end

        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/pipe_stimulus.txt
// All values hex. Test count, then per test a program, a mem_wait and a record line
// Program: word count, instruction words (count 0 reruns the program in memory)
// mem_wait: window count, then start cycle and length per window, counted from start
// Records: count, then rd, we, stalls (2 digits), data (4 digits) packed per word
// rd and data are not compared when we is 0
5
// Independent ALU and ADDI sequence
8 6205 6403 663E 680C 1A50 2C58 5F10 9000
0
7 11000005 21000003 3100FFFE 4100000C 51000008 61000007 7100000F
// Dependency distances of one and two
8 6207 6441 660C 3898 6A03 6C01 4F60 9000
0
7 11000007 21020008 3100000C 41020008 51000003 61000001 7101000B
// Store, load back, load-use
6 6209 6415 8050 7650 18D0 9000
0
5 11000009 21000015 00020000 31000015 4102002A
// Dependency program again with two mem_wait windows
8 6207 6441 660C 3898 6A03 6C01 4F60 9000
2 6 4 D 3
7 11000007 21020008 3100000C 41020008 51000003 61000001 7101000B
// Second start without reload
0
0
7 11000007 21020008 3100000C 41020008 51000003 61000001 7101000B

// File: flist.f
hw/pipe_pkg.sv
hw/instr_fetch.sv
hw/decode_regfile.sv
hw/pipe_ctrl.sv
hw/exec_alu.sv
hw/mem_stage.sv
hw/retire_tracker.sv
hw/pipe_top.sv
verif/tb_clk_gen.sv
verif/pipe_assertions.sv
verif/pipe_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module pipe_tb -f flist.f -o Vpipe_tb
	./obj_dir/Vpipe_tb | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
